// File: hw/vec_defs.svh
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// vector geometry shared by every stage
`define VEC_LEN 16  // elements per bank
`define ADDR_W  4   // element address bits, log2 of VEC_LEN

// data widths
`define ELEM_W  10  // element width, low byte plus two high bits
`define RES_W   32  // unsigned result width

`endif

// File: hw/vec_pkg.sv
`include "vec_defs.svh"

package vec_pkg;

    // opcodes as they sit in bits 2..0 of a command byte
    typedef enum logic [2:0] {
        op_write = 3'd0,  // load a bank
        op_read  = 3'd1,  // single element readback
        op_sum   = 3'd2,  // sum of a+b
        op_man   = 3'd3,  // manhattan distance
        op_dot   = 3'd4   // dot product
    } op_e;  // codes 5..7 are ignored by the decoder

    // decoder to engine
    typedef struct packed {
        op_e                op;        // operation to run
        logic               bank_sel;  // 0 bank a, 1 bank b
        logic [`ADDR_W-1:0] addr;      // element address, read only
    } cmd_t;

    // decoder to write_ctrl, one raw byte of a write
    typedef struct packed {
        logic [7:0] byte_data;  // low byte or high bits
        logic       bank_sel;   // target bank
    } wr_t;

    // shared write port of both banks
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;  // element address
        logic [`ELEM_W-1:0] data;  // packed element
    } mem_wr_t;

    // engine to the outside
    typedef struct packed {
        op_e               op;     // opcode that produced the value
        logic [`RES_W-1:0] value;  // zero extended for read
    } result_t;

endpackage

// File: hw/command_decoder.sv
`timescale 1ns/1ps
`include "vec_defs.svh"

module command_decoder (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rx_ready,       // one cycle per received byte
    input  logic [7:0]     rx_data,
    input  logic           write_done,     // from write_ctrl
    input  logic           op_done,        // from engine
    output logic           command_ready,  // pulse per accepted command
    output logic           wr_byte_valid,  // raw byte for write_ctrl
    output vec_pkg::wr_t   wr_byte,
    output logic           cmd_valid,      // pulse to engine
    output vec_pkg::cmd_t  cmd
);
    import vec_pkg::*;

    typedef enum logic [1:0] {
        s_idle,   // waiting for a command byte
        s_write,  // bytes go to write_ctrl
        s_raddr,  // next byte is a read address
        s_busy    // engine running, bytes dropped
    } state_e;

    state_e     state;
    logic [2:0] opcode;
    logic       op_ok;     // opcode 0..4
    logic       accept;    // a command byte may be taken this cycle
    logic       new_cmd;   // valid command byte accepted
    logic       raddr_hit; // address byte of a read
    logic       bank_q;    // bank select of the running command

    assign opcode    = rx_data[2:0];
    assign op_ok     = (opcode <= 3'd4);
    // the cycle that ends a write or an operation already behaves as idle
    assign accept    = (state == s_idle) || (state == s_write && write_done) ||
                       (state == s_busy && op_done);
    assign new_cmd   = rx_ready && accept && op_ok;
    assign raddr_hit = rx_ready && (state == s_raddr);

    // write bytes pass straight through so the element lands one cycle after its byte
    assign wr_byte_valid     = rx_ready && (state == s_write) && !write_done;
    assign wr_byte.byte_data = rx_data;
    assign wr_byte.bank_sel  = bank_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= s_idle;
            command_ready <= 1'b0;
            cmd_valid     <= 1'b0;
        end else begin
            command_ready <= new_cmd;
            cmd_valid     <= 1'b0;
            if (new_cmd) begin
                case (op_e'(opcode))
                    op_write: state <= s_write;
                    op_read:  state <= s_raddr;  // wait for the address byte
                    default: begin
                        state     <= s_busy;     // sum, man, dot start right away
                        cmd_valid <= 1'b1;
                    end
                endcase
            end else begin
                case (state)
                    s_write: if (write_done) state <= s_idle;
                    s_raddr: begin
                        if (raddr_hit) begin
                            state     <= s_busy;
                            cmd_valid <= 1'b1;
                        end
                    end
                    s_busy:  if (op_done) state <= s_idle;
                    default: state <= s_idle;
                endcase
            end
        end
    end

    // command payload, only meaningful with cmd_valid
    always_ff @(posedge clk) begin
        if (new_cmd) begin
            bank_q       <= rx_data[7];
            cmd.op       <= op_e'(opcode);
            cmd.bank_sel <= rx_data[7];
            cmd.addr     <= '0;  // sweeps start at element 0
        end else if (raddr_hit) begin
            cmd.op   <= op_read;
            cmd.addr <= rx_data[`ADDR_W-1:0];  // bank select kept from the command
        end
    end

endmodule

// File: hw/write_ctrl.sv
`timescale 1ns/1ps
`include "vec_defs.svh"

module write_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_byte_valid,  // byte forwarded by the decoder
    input  vec_pkg::wr_t      wr_byte,
    output logic              wr_a_en,        // write strobe, bank a
    output logic              wr_b_en,        // write strobe, bank b
    output vec_pkg::mem_wr_t  mem_wr,         // shared by both banks
    output logic              write_done      // after the last element
);
    import vec_pkg::*;

    localparam logic [`ADDR_W-1:0] last_addr = `ADDR_W'(`VEC_LEN - 1);

    logic               phase;     // 0 low byte expected, 1 high byte expected
    logic [7:0]         low_q;     // held low byte
    logic [`ADDR_W-1:0] wr_addr;   // element counter
    logic               low_hit;   // low byte this cycle
    logic               high_hit;  // high byte, element complete

    assign low_hit  = wr_byte_valid && !phase;
    assign high_hit = wr_byte_valid && phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= 1'b0;
            wr_addr    <= '0;
            wr_a_en    <= 1'b0;
            wr_b_en    <= 1'b0;
            write_done <= 1'b0;
        end else begin
            wr_a_en    <= 1'b0;  // strobes last one cycle
            wr_b_en    <= 1'b0;
            write_done <= 1'b0;
            if (low_hit) begin
                phase <= 1'b1;
            end
            if (high_hit) begin
                phase   <= 1'b0;
                wr_a_en <= !wr_byte.bank_sel;
                wr_b_en <= wr_byte.bank_sel;
                if (wr_addr == last_addr) begin
                    wr_addr    <= '0;    // wrap for the next write command
                    write_done <= 1'b1;  // same cycle as the last element write
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (low_hit) begin
            low_q <= wr_byte.byte_data;
        end
        if (high_hit) begin
            mem_wr.addr <= wr_addr;
            // only the two lsbs of the high byte are element bits
            mem_wr.data <= {wr_byte.byte_data[`ELEM_W-9:0], low_q};
        end
    end

endmodule

// File: hw/vector_bank.sv
`timescale 1ns/1ps
`include "vec_defs.svh"

module vector_bank (
    input  logic               clk,
    input  logic               wr_en,    // write strobe of this bank
    input  vec_pkg::mem_wr_t   mem_wr,   // address and element
    input  logic [`ADDR_W-1:0] rd_addr,  // from the engine
    output logic [`ELEM_W-1:0] rd_data   // one cycle after rd_addr
);

    // block ram style array, contents undefined until written
    logic [`ELEM_W-1:0] mem [`VEC_LEN];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // registered read port, old data on a same address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hw/vector_engine.sv
`timescale 1ns/1ps
`include "vec_defs.svh"

module vector_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,     // start pulse from the decoder
    input  vec_pkg::cmd_t      cmd,
    input  logic [`ELEM_W-1:0] rd_data_a,     // bank a, one cycle after rd_addr
    input  logic [`ELEM_W-1:0] rd_data_b,     // bank b
    output logic [`ADDR_W-1:0] rd_addr,       // shared by both banks
    output logic               op_done,       // back to the decoder
    output logic               result_valid,  // result pulse
    output vec_pkg::result_t   result
);
    import vec_pkg::*;

    localparam logic [`ADDR_W-1:0] last_addr = `ADDR_W'(`VEC_LEN - 1);

    logic               sweeping;    // addresses 1..last still to issue
    logic [`ADDR_W-1:0] sweep_addr;  // next sweep address
    logic               rd_vld;      // bank outputs hold a wanted element
    logic               rd_last;     // ... and it is the final one
    op_e                op_q;        // latched opcode
    logic               bank_q;      // latched bank, read only
    logic [`RES_W-1:0]  acc;         // running sum
    logic [`RES_W-1:0]  a_ext;
    logic [`RES_W-1:0]  b_ext;
    logic [`RES_W-1:0]  term;        // contribution of this element pair
    logic [`RES_W-1:0]  acc_next;

    // first address goes out in the command cycle, saves one cycle of latency
    assign rd_addr = cmd_valid ? ((cmd.op == op_read) ? cmd.addr : '0) : sweep_addr;

    assign a_ext = `RES_W'(rd_data_a);  // zero extend, all values unsigned
    assign b_ext = `RES_W'(rd_data_b);

    always_comb begin
        case (op_q)
            op_sum:  term = a_ext + b_ext;
            op_man:  term = (a_ext > b_ext) ? (a_ext - b_ext) : (b_ext - a_ext);
            op_dot:  term = a_ext * b_ext;  // 20 bit product at most
            default: term = bank_q ? b_ext : a_ext;  // read, acc starts at 0
        endcase
    end

    assign acc_next = acc + term;
    assign op_done  = result_valid;  // decoder frees up with the result

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweeping     <= 1'b0;
            sweep_addr   <= '0;
            rd_vld       <= 1'b0;
            rd_last      <= 1'b0;
            op_q         <= op_sum;
            bank_q       <= 1'b0;
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            rd_vld       <= 1'b0;
            rd_last      <= 1'b0;
            result_valid <= 1'b0;
            if (cmd_valid) begin
                op_q    <= cmd.op;
                bank_q  <= cmd.bank_sel;
                acc     <= '0;
                rd_vld  <= 1'b1;                 // address went out this cycle
                rd_last <= (cmd.op == op_read);  // a read is a single element
                if (cmd.op != op_read) begin
                    sweeping   <= 1'b1;
                    sweep_addr <= `ADDR_W'(1);
                end
            end else if (sweeping) begin
                rd_vld  <= 1'b1;
                rd_last <= (sweep_addr == last_addr);
                if (sweep_addr == last_addr) begin
                    sweeping <= 1'b0;
                end
                sweep_addr <= sweep_addr + 1'b1;
            end
            if (rd_vld) begin
                acc          <= acc_next;
                result_valid <= rd_last;  // final element accumulated
            end
        end
    end

    // result payload, held until the next operation ends
    always_ff @(posedge clk) begin
        if (rd_vld && rd_last) begin
            result.op    <= op_q;
            result.value <= acc_next;
        end
    end

endmodule

// File: hw/vector_input_top.sv
`timescale 1ns/1ps
`include "vec_defs.svh"

module vector_input_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx_ready,       // byte strobe from the receiver
    input  logic [7:0]        rx_data,
    output logic              command_ready,  // pulse per accepted command
    output logic              write_done,     // pulse after a bank load
    output logic              result_valid,   // pulse with each result
    output vec_pkg::result_t  result
);
    import vec_pkg::*;

    logic               wr_byte_valid;  // decoder to write_ctrl
    wr_t                wr_byte;
    logic               cmd_valid;      // decoder to engine
    cmd_t               cmd;
    logic               op_done;        // engine to decoder
    logic               wr_a_en;        // write_ctrl to banks
    logic               wr_b_en;
    mem_wr_t            mem_wr;
    logic [`ADDR_W-1:0] rd_addr;        // engine to banks
    logic [`ELEM_W-1:0] rd_data_a;
    logic [`ELEM_W-1:0] rd_data_b;

    command_decoder u_command_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_ready      (rx_ready),
        .rx_data       (rx_data),
        .write_done    (write_done),
        .op_done       (op_done),
        .command_ready (command_ready),
        .wr_byte_valid (wr_byte_valid),
        .wr_byte       (wr_byte),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd)
    );

    write_ctrl u_write_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_byte_valid (wr_byte_valid),
        .wr_byte       (wr_byte),
        .wr_a_en       (wr_a_en),
        .wr_b_en       (wr_b_en),
        .mem_wr        (mem_wr),
        .write_done    (write_done)  // also ends the write state in the decoder
    );

    vector_bank bank_a (.clk(clk), .wr_en(wr_a_en), .mem_wr(mem_wr), .rd_addr(rd_addr),
                        .rd_data(rd_data_a));

    vector_bank bank_b (.clk(clk), .wr_en(wr_b_en), .mem_wr(mem_wr), .rd_addr(rd_addr),
                        .rd_data(rd_data_b));

    vector_engine u_vector_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .rd_addr      (rd_addr),
        .op_done      (op_done),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: verification/vector_input_asserts.sv
`timescale 1ns/1ps

module vector_input_asserts (
    input logic clk,
    input logic rst_n,
    input logic command_ready,  // top level strobes
    input logic write_done,
    input logic result_valid
);

    // every strobe is a single cycle pulse
    cmd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        command_ready |=> !command_ready)
        else $error("command_ready stayed high for more than one cycle");

    wdone_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        write_done |=> !write_done)
        else $error("write_done stayed high for more than one cycle");

    result_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid stayed high for more than one cycle");

    // outputs are quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(command_ready || write_done || result_valid))
        else $error("output pulse seen while reset was asserted");

    // decoder is busy while a result is produced, so no command is taken then
    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && command_ready))
        else $error("result_valid and command_ready high in the same cycle");

endmodule

bind vector_input_top vector_input_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .command_ready (command_ready),
    .write_done    (write_done),
    .result_valid  (result_valid)
);

// File: verification/vector_input_tb.sv
`timescale 1ns/1ps
`include "vec_defs.svh"

module vector_input_tb;
    import vec_pkg::*;

    logic               clk;
    logic               rst_n;
    logic               rx_ready;
    logic [7:0]         rx_data;
    logic               command_ready;
    logic               write_done;
    logic               result_valid;
    result_t            result;

    logic [`ELEM_W-1:0] model_a [`VEC_LEN];    // reference copy of bank a
    logic [`ELEM_W-1:0] model_b [`VEC_LEN];    // reference copy of bank b
    logic [31:0]        lfsr = 32'heeef_74df;  // idle gap generator
    string              lines[$];              // trace records in file order
    result_t            last_result;           // latest result seen on the bus
    int                 n_cmd = 0;             // observed pulses
    int                 n_wdone = 0;
    int                 n_result = 0;
    int                 exp_cmd = 0;           // pulses the trace should produce
    int                 exp_wdone = 0;
    int                 exp_result = 0;
    int                 cycles = 0;
    int                 cycle_limit = 0;       // 0 until the trace is read
    int                 errors = 0;

    vector_input_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_ready      (rx_ready),
        .rx_data       (rx_data),
        .command_ready (command_ready),
        .write_done    (write_done),
        .result_valid  (result_valid),
        .result        (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // strobes sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (command_ready) n_cmd++;
        if (write_done) n_wdone++;
        if (result_valid) begin
            last_result = result;  // payload first, the waiter wakes on the count
            n_result++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            abort_run($sformatf("timeout, no response from the DUT after %0d cycles", cycles));
        end
    end

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_result(input string name, input result_t want, input result_t got);
        if (want !== got) begin
            abort_run($sformatf("FAIL %s expected op %0d value %h actual op %0d value %h",
                                name, want.op, want.value, got.op, got.value));
        end
    endtask

    task automatic check_pulse(input string name, input int want, input int got);
        if (want != got) begin
            abort_run($sformatf("FAIL %s expected %0d actual %0d", name, want, got));
        end
    endtask

    // right shifting galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'hA300_0000;
        return s >> 1;
    endfunction

    task automatic draw_gap(output logic [1:0] gap);
        int i;
        for (i = 0; i < 2; i++) begin
            gap[i] = lfsr[0];  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // one byte with a one cycle rx_ready, after 0..3 idle cycles
    task automatic send_byte(input logic [7:0] b);
        logic [1:0] gap;
        draw_gap(gap);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        rx_ready <= 1'b1;
        rx_data  <= b;
        @(posedge clk);
        rx_ready <= 1'b0;  // byte taken at this edge
    endtask

    // sum, man or dot over the reference banks
    function automatic logic [`RES_W-1:0] model_value(input logic [2:0] op);
        logic [`RES_W-1:0] acc;
        logic [`RES_W-1:0] a;
        logic [`RES_W-1:0] b;
        int                i;
        acc = '0;
        for (i = 0; i < `VEC_LEN; i++) begin
            a = `RES_W'(model_a[i]);
            b = `RES_W'(model_b[i]);
            case (op)
                op_sum:  acc = acc + a + b;
                op_man:  acc = acc + ((a > b) ? a - b : b - a);
                default: acc = acc + a * b;
            endcase
        end
        return acc;
    endfunction

    task automatic run_record(input int idx, input string line);
        logic [7:0]  tag;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] e [`VEC_LEN];
        logic [31:0] want;
        result_t     exp_r;
        string       name;
        int          n;
        int          i;
        tag  = line[0];
        want = '0;
        f3   = '0;
        name = $sformatf("record %0d", idx);
        case (tag)
            "W": begin
                n = $sscanf(line, "W %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f1, e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7],
                            e[8], e[9], e[10], e[11], e[12], e[13], e[14], e[15]);
                if (n != 17) abort_run($sformatf("%s has not 16 elements", name));
                send_byte({f1[0], 7'd0});  // write opcode is 0
                for (i = 0; i < `VEC_LEN; i++) begin
                    send_byte(e[i][7:0]);          // low byte first
                    send_byte({6'd0, e[i][9:8]});  // then the two top bits
                    if (f1[0]) model_b[i] = e[i][`ELEM_W-1:0];
                    else model_a[i] = e[i][`ELEM_W-1:0];
                end
                exp_wdone++;
                wait (n_wdone >= exp_wdone);
            end
            "R": begin
                n = $sscanf(line, "R %h %h %h", f1, f2, f3);
                if (n != 3) abort_run($sformatf("%s is not a valid read record", name));
                want     = 32'(f1[0] ? model_b[f2[3:0]] : model_a[f2[3:0]]);
                exp_r.op = op_read;
                name     = $sformatf("%s read bank %0d addr %0d", name, f1[0], f2[3:0]);
                send_byte({f1[0], 4'd0, op_read});
                send_byte({4'd0, f2[3:0]});  // element address
            end
            "C", "B": begin
                if (tag == "C") n = $sscanf(line, "C %h %h", f1, f3) + 1;
                else n = $sscanf(line, "B %h %h %h", f1, f2, f3);
                if (n != 3) abort_run($sformatf("%s is not a valid compute record", name));
                want     = model_value(f1[2:0]);
                exp_r.op = op_e'(f1[2:0]);
                name     = $sformatf("%s op %0d", name, f1[2:0]);
                send_byte({5'd0, f1[2:0]});
                if (tag == "B") begin
                    repeat (2) @(posedge clk);  // sweep is running by now
                    send_byte(f2[7:0]);         // must be dropped
                end
            end
            default: abort_run($sformatf("%s has an unknown record type", name));
        endcase
        exp_cmd++;
        if (tag != "W") begin
            if (want != f3) begin
                abort_run($sformatf("%s trace value %h differs from the reference model %h",
                                    name, f3, want));
            end
            exp_r.value = want;
            exp_result++;
            wait (n_result >= exp_result);
            check_result(name, exp_r, last_result);
        end
        check_pulse({name, " command_ready count"}, exp_cmd, n_cmd);
        check_pulse({name, " write_done count"}, exp_wdone, n_wdone);
        check_pulse({name, " result_valid count"}, exp_result, n_result);
    endtask

    initial begin
        int         fd;
        int         k;
        int         n_bytes;
        int         n_compute;
        string      line;
        logic [7:0] tag;
        rst_n    <= 1'b0;
        rx_ready <= 1'b0;
        rx_data  <= 8'h00;
        n_bytes   = 0;
        n_compute = 0;
        fd = $fopen("verification/vector_trace.txt", "r");
        if (fd == 0) abort_run("cannot open the trace file verification/vector_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1) begin
                tag = line[0];
                if (tag != "#") begin  // comment lines skipped
                    lines.push_back(line);
                    case (tag)
                        "W":     n_bytes += 1 + 2 * `VEC_LEN;
                        "R":     n_bytes += 2;
                        "B":     n_bytes += 2;
                        default: n_bytes += 1;
                    endcase
                    if (tag == "C" || tag == "B") n_compute++;
                end
            end
        end
        $fclose(fd);
        cycle_limit = 16 + 10 + 5 * n_bytes + 40 * n_compute;  // reset and idle check first

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) @(negedge clk);  // nothing sent yet, outputs stay low
        check_pulse("command_ready before first byte", 0, n_cmd);
        check_pulse("write_done before first byte", 0, n_wdone);
        check_pulse("result_valid before first byte", 0, n_result);

        for (k = 0; k < lines.size(); k++) begin
            run_record(k, lines[k]);
        end
        repeat (5) @(negedge clk);  // catch late extra pulses
        check_pulse("final command_ready count", exp_cmd, n_cmd);
        check_pulse("final write_done count", exp_wdone, n_wdone);
        check_pulse("final result_valid count", exp_result, n_result);

        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/vec_pkg.sv
hw/command_decoder.sv
hw/write_ctrl.sv
hw/vector_bank.sv
hw/vector_engine.sv
hw/vector_input_top.sv
verification/vector_input_asserts.sv
verification/vector_input_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the vector input testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vector_input_tb -f files.f -o vsim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vsim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: verification/vector_trace.txt
# W bank e0..e15 loads a bank | R bank addr value reads one element
# C op value runs sum 2, man 3, dot 4 | B op stray value also sends a stray byte mid sweep
# all fields hex, value is the expected 32-bit result

# bank a holds 64*i+3, bank b holds 1000-50*i
W 0 003 043 083 0c3 103 143 183 1c3 203 243 283 2c3 303 343 383 3c3
W 1 3e8 3b6 384 352 320 2ee 2bc 28a 258 226 1f4 1c2 190 15e 12c 0fa

# same addresses from both banks
R 0 5 143
R 1 5 2ee
R 0 0 003
R 1 0 3e8
R 0 f 3c3
R 1 f 0fa

C 2 4540
C 3 1d2a
C 4 391930

# a dot command during the sum sweep is dropped
B 2 84 4540
C 4 391930

# bank a overwritten with 1023-64*i, bank b untouched
W 0 3ff 3bf 37f 33f 2ff 2bf 27f 23f 1ff 1bf 17f 13f 0ff 0bf 07f 03f
R 0 3 33f
R 1 3 352
R 0 c 0ff
R 1 a 1f4

C 2 4900
C 3 560
C 4 6374f0

# a read command during the man sweep is dropped
B 3 01 560
R 1 f 0fa
C 2 4900
